// ==== hub75_driver.f ====
+incdir+logic
logic/pov_panel_pkg.sv
logic/column_buffer.sv
logic/bcm_timer.sv
logic/hub75_scan_ctrl.sv
logic/hub75_driver.sv
test/hub75_driver_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the hub75_driver testbench with Verilator and run it.
# The simulator exits non-zero when the testbench ends in $fatal.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
   --top-module hub75_driver_tb \
   -f hub75_driver.f \
   -o hub75_driver_sim

./obj_dir/hub75_driver_sim

// ==== test/hub75_driver_tb.sv ====
`timescale 1ns/1ps
`include "hub75_macros.svh"

module hub75_driver_tb;

   localparam int CLK_PERIOD  = 40;
   localparam int RESET_CYCLES = 8;
   localparam int NUM_COLUMNS = 20;
   localparam int NUM_COLS    = `HUB75_NUM_COLS;
   localparam int PLANES      = `HUB75_PLANES;
   localparam int ADDR_W      = `HUB75_ADDR_W;

   // transfer edge to the edge that brings tready back
   // per plane: shift, one latch cycle, weighted hold
   localparam int CYCLES_PER_COLUMN =
      PLANES * (NUM_COLS + 1) + `HUB75_BASE_PERIOD * ((1 << PLANES) - 1);

   localparam int MAX_GAP = 270 + 15;  // longest idle gap the stimulus picks
   localparam int TIMEOUT_CYCLES =
      RESET_CYCLES + 100 + NUM_COLUMNS * (CYCLES_PER_COLUMN + MAX_GAP + 2);

   logic clk_in;
   logic rst_in;
   logic tvalid;
   logic tready;
   pov_panel_pkg::pixel_t [NUM_COLS-1:0] upper_column;
   pov_panel_pkg::pixel_t [NUM_COLS-1:0] lower_column;
   logic [ADDR_W-1:0] address_data;
   logic [2:0]        rgb0;
   logic [2:0]        rgb1;
   logic              led_clk;
   logic              led_latch;
   logic              led_output_enable;
   logic [ADDR_W-1:0] hub75_address;

   // columns in the order they were accepted
   pov_panel_pkg::pixel_t [NUM_COLS-1:0] sent_upper [NUM_COLUMNS];
   pov_panel_pkg::pixel_t [NUM_COLS-1:0] sent_lower [NUM_COLUMNS];

   integer seed;
   int     clk_edges;         // rising led_clk edges since reset
   int     holds_checked;
   int     columns_finished;  // tready returns seen
   logic   pixels_checked;

   hub75_driver hub75_driver_i (
      .clk_in            (clk_in),
      .rst_in            (rst_in),
      .tvalid            (tvalid),
      .tready            (tready),
      .upper_column      (upper_column),
      .lower_column      (lower_column),
      .address_data      (address_data),
      .rgb0              (rgb0),
      .rgb1              (rgb1),
      .led_clk           (led_clk),
      .led_latch         (led_latch),
      .led_output_enable (led_output_enable),
      .hub75_address     (hub75_address)
   );

   initial begin
      clk_in = 1'b0;
      forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
   end

   // expected panel bits, bit c is colour c at this plane
   function automatic logic [2:0] expected_rgb(input pov_panel_pkg::pixel_t pix,
                                               input int plane);
      logic [2:0] bits;
      bits[0] = pix[plane];               // red 2:0
      bits[1] = pix[PLANES + plane];      // green 5:3
      bits[2] = pix[2 * PLANES + plane];  // blue 8:6
      return bits;
   endfunction

   task automatic check_value(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
      if (actual !== expected) begin
         $display("error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
         $display("Done: errors found");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   // fresh random payload on the stream inputs
   task automatic drive_random_column();
      for (int i = 0; i < NUM_COLS; i++) begin
         upper_column[i] = pov_panel_pkg::pixel_t'($random(seed));
         lower_column[i] = pov_panel_pkg::pixel_t'($random(seed));
      end
      address_data = ADDR_W'($random(seed));
   endtask

   // idle gap, then hold tvalid with changing data until accepted
   task automatic send_column(input int n);
      logic [31:0] r;
      int          gap;
      logic        accepted;
      r = $random(seed);
      gap = (r[1:0] == 2'd0) ? 270 + int'(r[5:2]) : int'(r[3:2]);  // long gap reaches idle
      repeat (gap) begin
         @(posedge clk_in);
         #2;
         tvalid = 1'b0;
      end
      accepted = 1'b0;
      while (!accepted) begin
         @(posedge clk_in);
         #2;
         tvalid = 1'b1;
         drive_random_column();  // ignored while tready low
         #6;
         if (tready) begin  // taken on the next edge
            accepted      = 1'b1;
            sent_upper[n] = upper_column;
            sent_lower[n] = lower_column;
         end
      end
   endtask

   always @(posedge led_clk) begin
      if (rst_in === 1'b0)
         clk_edges++;
   end

   // panel data pins, sampled where the panel shifts them in
   initial begin : pixel_monitor
      pov_panel_pkg::pixel_t up_pix;
      pov_panel_pkg::pixel_t lo_pix;
      wait (rst_in === 1'b0);
      for (int n = 0; n < NUM_COLUMNS; n++) begin
         for (int p = 0; p < PLANES; p++) begin
            for (int i = 0; i < NUM_COLS; i++) begin
               @(posedge led_clk);
               up_pix = sent_upper[n][i];
               lo_pix = sent_lower[n][i];
               check_value("rgb0", 64'(rgb0), 64'(expected_rgb(up_pix, p)));
               check_value("rgb1", 64'(rgb1), 64'(expected_rgb(lo_pix, p)));
               check_value("led_output_enable", 64'(led_output_enable), 64'(0));  // dark while shifting
               check_value("led_latch", 64'(led_latch), 64'(0));
            end
         end
      end
      pixels_checked = 1'b1;
   end

   // control pins once per cycle, mid high phase
   initial begin : control_monitor
      int                cyc;
      int                xfer_cyc;
      int                hold_run;
      int                hold_plane;
      int                last_latch_edges;
      logic              prev_tready;
      logic              prev_latch;
      logic [ADDR_W-1:0] addr_exp;
      cyc              = 0;
      xfer_cyc         = 0;
      hold_run         = 0;
      hold_plane       = 0;
      last_latch_edges = 0;
      prev_tready      = 1'b1;
      prev_latch       = 1'b0;
      addr_exp         = '0;  // reset value until the first transfer
      wait (rst_in === 1'b0);
      forever begin
         @(posedge clk_in);
         #10;
         cyc++;
         check_value("hub75_address", 64'(hub75_address), 64'(addr_exp));
         if (led_latch) begin
            check_value("led_latch before pulse", 64'(prev_latch), 64'(0));  // one cycle only
            check_value("led_clk edges per plane", 64'(clk_edges - last_latch_edges),
                        64'(NUM_COLS));
            check_value("led_output_enable", 64'(led_output_enable), 64'(0));
            last_latch_edges = clk_edges;
         end
         if (led_output_enable) begin
            hold_run++;
         end else if (hold_run > 0) begin  // hold just ended
            check_value("hold cycles", 64'(hold_run),
                        64'(`HUB75_BASE_PERIOD << hold_plane));
            check_value("led_clk edges during hold", 64'(clk_edges), 64'(last_latch_edges));
            hold_run   = 0;
            hold_plane = (hold_plane + 1) % PLANES;
            holds_checked++;
         end
         if (tready && !prev_tready) begin
            check_value("cycles to tready", 64'(cyc - xfer_cyc), 64'(CYCLES_PER_COLUMN));
            columns_finished++;
         end
         if (tvalid && tready) begin
            xfer_cyc = cyc + 1;     // edge that takes the column
            addr_exp = address_data;
         end
         prev_tready = tready;
         prev_latch  = led_latch;
      end
   end

   initial begin : watchdog
      #(TIMEOUT_CYCLES * CLK_PERIOD);
      $display("timeout: columns not displayed after %0d clock cycles", TIMEOUT_CYCLES);
      $display("Done: errors found");
      $fatal(1, "watchdog expired");
   end

   initial begin
      seed             = 32'h690a_9a53;
      rst_in           = 1'b1;
      tvalid           = 1'b0;
      upper_column     = '0;
      lower_column     = '0;
      address_data     = '0;
      clk_edges        = 0;
      holds_checked    = 0;
      columns_finished = 0;
      pixels_checked   = 1'b0;

      repeat (RESET_CYCLES) @(posedge clk_in);
      #2;
      rst_in = 1'b0;

      // state straight out of reset
      #8;
      check_value("tready", 64'(tready), 64'(1));
      check_value("led_latch", 64'(led_latch), 64'(0));
      check_value("led_output_enable", 64'(led_output_enable), 64'(0));
      check_value("hub75_address", 64'(hub75_address), 64'(0));
      check_value("scan state", 64'(hub75_driver_i.hub75_scan_ctrl_i.state),
                  64'(pov_panel_pkg::scan_idle));
      @(negedge clk_in);
      #2;
      check_value("led_clk", 64'(led_clk), 64'(0));  // low phase, mask shows through

      for (int n = 0; n < NUM_COLUMNS; n++)
         send_column(n);
      @(posedge clk_in);
      #2;
      tvalid = 1'b0;

      wait (pixels_checked && columns_finished == NUM_COLUMNS);
      @(posedge clk_in);
      #10;
      if (holds_checked == NUM_COLUMNS * PLANES &&
          clk_edges == NUM_COLUMNS * PLANES * NUM_COLS && tready) begin
         $display("Done: no errors");
         $finish;
      end else begin
         $display("final counts of holds or panel clock edges do not match the columns sent");
         $display("Done: errors found");
         $fatal(1, "count mismatch at end of run");
      end
   end

endmodule

// ==== logic/hub75_driver.sv ====
`timescale 1ns/1ps
`include "hub75_macros.svh"

module hub75_driver (
   input  logic                                        clk_in,
   input  logic                                        rst_in,
   // column stream in
   input  logic                                        tvalid,
   output logic                                        tready,
   input  pov_panel_pkg::pixel_t [`HUB75_NUM_COLS-1:0] upper_column,
   input  pov_panel_pkg::pixel_t [`HUB75_NUM_COLS-1:0] lower_column,
   input  logic [`HUB75_ADDR_W-1:0]                    address_data,
   // panel pins
   output logic [2:0]                                  rgb0,
   output logic [2:0]                                  rgb1,
   output logic                                        led_clk,
   output logic                                        led_latch,
   output logic                                        led_output_enable,
   output logic [`HUB75_ADDR_W-1:0]                    hub75_address
);

   logic                      load;         // capture strobe
   logic [`HUB75_PIX_W-1:0]   pixel_index;
   logic [`HUB75_PLANE_W-1:0] plane;
   logic                      hold_start;
   logic                      hold_done;

   // sequencing, handshake and panel control lines
   hub75_scan_ctrl hub75_scan_ctrl_i (
      .clk_in            (clk_in),
      .rst_in            (rst_in),
      .tvalid            (tvalid),
      .address_data      (address_data),
      .hold_done         (hold_done),
      .tready            (tready),
      .load              (load),
      .pixel_index       (pixel_index),
      .plane             (plane),
      .hold_start        (hold_start),
      .led_clk           (led_clk),
      .led_latch         (led_latch),
      .led_output_enable (led_output_enable),
      .hub75_address     (hub75_address)
   );

   // both halves, plane bit select
   column_buffer column_buffer_i (
      .clk_in       (clk_in),
      .rst_in       (rst_in),
      .load         (load),
      .upper_column (upper_column),
      .lower_column (lower_column),
      .pixel_index  (pixel_index),
      .plane        (plane),
      .rgb0         (rgb0),
      .rgb1         (rgb1)
   );

   // weighted hold
   bcm_timer bcm_timer_i (
      .clk_in (clk_in),
      .rst_in (rst_in),
      .start  (hold_start),
      .plane  (plane),
      .done   (hold_done)
   );

endmodule

// ==== logic/hub75_scan_ctrl.sv ====
`timescale 1ns/1ps
`include "hub75_macros.svh"

module hub75_scan_ctrl (
   input  logic                      clk_in,
   input  logic                      rst_in,
   input  logic                      tvalid,
   input  logic [`HUB75_ADDR_W-1:0]  address_data,
   input  logic                      hold_done,
   output logic                      tready,
   output logic                      load,
   output logic [`HUB75_PIX_W-1:0]   pixel_index,
   output logic [`HUB75_PLANE_W-1:0] plane,
   output logic                      hold_start,
   output logic                      led_clk,
   output logic                      led_latch,
   output logic                      led_output_enable,
   output logic [`HUB75_ADDR_W-1:0]  hub75_address
);

   localparam int PIX_W   = `HUB75_PIX_W;
   localparam int PLANE_W = `HUB75_PLANE_W;

   localparam logic [PIX_W-1:0]   LAST_PIX   = PIX_W'(`HUB75_NUM_COLS - 1);
   localparam logic [PLANE_W-1:0] LAST_PLANE = PLANE_W'(`HUB75_PLANES - 1);

   pov_panel_pkg::scan_state_t state;

   logic shift_mask;  // registered, gates the panel clock
   logic last_pix;
   logic last_plane;

   // handshake, ready only while idle
   assign tready = (state == pov_panel_pkg::scan_idle);
   assign load   = tvalid && tready;

   assign last_pix   = (pixel_index == LAST_PIX);
   assign last_plane = (plane == LAST_PLANE);

   // timer kicks off as the latch cycle ends
   assign hold_start = (state == pov_panel_pkg::scan_latch);

   // inverted clk so the panel sees a rising edge mid-cycle,
   // data from the buffer is settled by then
   assign led_clk = ~clk_in & shift_mask;

   always_ff @(posedge clk_in) begin
      if (rst_in) begin
         state             <= pov_panel_pkg::scan_idle;
         pixel_index       <= '0;
         plane             <= '0;
         shift_mask        <= 1'b0;
         led_latch         <= 1'b0;
         led_output_enable <= 1'b0;
         hub75_address     <= '0;
      end else begin
         case (state)
            pov_panel_pkg::scan_idle: begin
               if (load) begin
                  state         <= pov_panel_pkg::scan_shift;
                  hub75_address <= address_data;  // held for the whole column
                  pixel_index   <= '0;
                  plane         <= '0;
                  shift_mask    <= 1'b1;  // plane 0 shift starts next cycle
               end
            end

            pov_panel_pkg::scan_shift: begin
               if (last_pix) begin
                  state       <= pov_panel_pkg::scan_latch;
                  pixel_index <= '0;
                  shift_mask  <= 1'b0;  // stop panel clock
                  led_latch   <= 1'b1;
               end else begin
                  pixel_index <= pixel_index + 1'b1;
               end
            end

            pov_panel_pkg::scan_latch: begin
               state             <= pov_panel_pkg::scan_hold;
               led_latch         <= 1'b0;
               led_output_enable <= 1'b1;  // lit through the weighted hold
            end

            pov_panel_pkg::scan_hold: begin
               if (hold_done) begin
                  led_output_enable <= 1'b0;
                  if (last_plane) begin
                     state <= pov_panel_pkg::scan_idle;  // column finished
                  end else begin
                     state      <= pov_panel_pkg::scan_shift;
                     plane      <= plane + 1'b1;
                     shift_mask <= 1'b1;  // next plane, same column
                  end
               end
            end

            default: begin
               state <= pov_panel_pkg::scan_idle;
            end
         endcase
      end
   end

endmodule

// ==== logic/bcm_timer.sv ====
`timescale 1ns/1ps
`include "hub75_macros.svh"

module bcm_timer (
   input  logic                      clk_in,
   input  logic                      rst_in,
   input  logic                      start,
   input  logic [`HUB75_PLANE_W-1:0] plane,
   output logic                      done
);

   localparam int HOLD_W = `HUB75_HOLD_W;

   logic [HOLD_W-1:0] hold_len;  // binary weight, base << plane
   logic [HOLD_W-1:0] count;     // cycles left after the current one
   logic              active;

   assign hold_len = HOLD_W'(`HUB75_BASE_PERIOD) << plane;

   always_ff @(posedge clk_in) begin
      if (rst_in) begin
         count  <= '0;
         active <= 1'b0;
      end else if (start) begin
         count  <= hold_len - 1'b1;  // first hold cycle follows this edge
         active <= 1'b1;
      end else if (active) begin
         if (count == '0)
            active <= 1'b0;  // back to idle until the next plane
         else
            count <= count - 1'b1;
      end
   end

   // high in the last hold cycle only
   assign done = active && (count == '0);

endmodule

// ==== logic/column_buffer.sv ====
`timescale 1ns/1ps
`include "hub75_macros.svh"

module column_buffer (
   input  logic                                            clk_in,
   input  logic                                            rst_in,
   input  logic                                            load,
   input  pov_panel_pkg::pixel_t [`HUB75_NUM_COLS-1:0]     upper_column,
   input  pov_panel_pkg::pixel_t [`HUB75_NUM_COLS-1:0]     lower_column,
   input  logic [`HUB75_PIX_W-1:0]                         pixel_index,
   input  logic [`HUB75_PLANE_W-1:0]                       plane,
   output logic [2:0]                                      rgb0,
   output logic [2:0]                                      rgb1
);

   // stored halves, held for all three planes
   pov_panel_pkg::pixel_t [`HUB75_NUM_COLS-1:0] upper_q;
   pov_panel_pkg::pixel_t [`HUB75_NUM_COLS-1:0] lower_q;

   pov_panel_pkg::pixel_t upper_pix;  // addressed pixel, top half
   pov_panel_pkg::pixel_t lower_pix;  // addressed pixel, bottom half

   always_ff @(posedge clk_in) begin
      if (rst_in) begin
         upper_q <= '0;
         lower_q <= '0;
      end else if (load) begin  // one-cycle strobe from the controller
         upper_q <= upper_column;
         lower_q <= lower_column;
      end
   end

   // pixel mux
   assign upper_pix = upper_q[pixel_index];
   assign lower_pix = lower_q[pixel_index];

   // per colour c take bit 3c + plane
   // rgb bit 0 red, 1 green, 2 blue
   always_comb begin
      rgb0 = '0;
      rgb1 = '0;
      for (int c = 0; c < 3; c++) begin
         rgb0[c] = upper_pix[c * `HUB75_PLANES + int'(plane)];
         rgb1[c] = lower_pix[c * `HUB75_PLANES + int'(plane)];
      end
   end

endmodule

// ==== logic/pov_panel_pkg.sv ====
`include "hub75_macros.svh"

package pov_panel_pkg;

   // one pixel, red 2:0, green 5:3, blue 8:6
   // lsb of each channel is plane 0
   typedef logic [`HUB75_RGB_W-1:0] pixel_t;

   // scan controller states, one pass per bit plane
   typedef enum logic [1:0] {
      scan_idle  = 2'd0,  // waiting on tvalid
      scan_shift = 2'd1,  // clocking 64 pixels into the panel
      scan_latch = 2'd2,  // one-cycle latch pulse
      scan_hold  = 2'd3   // leds lit for the weighted period
   } scan_state_t;

endpackage

// ==== logic/hub75_macros.svh ====
`ifndef HUB75_MACROS_SVH
`define HUB75_MACROS_SVH

// panel geometry
`define HUB75_NUM_COLS    64  // pixels per half-column, shifted once per plane
`define HUB75_SCAN_RATE   32  // scan addresses on the panel

// colour depth, bits per channel = number of bcm planes
`define HUB75_PLANES      3

// hold of plane 0 in clk_in cycles, plane p holds base << p
`define HUB75_BASE_PERIOD 10

// derived widths
`define HUB75_ADDR_W  $clog2(`HUB75_SCAN_RATE)
`define HUB75_PIX_W   $clog2(`HUB75_NUM_COLS)
`define HUB75_PLANE_W $clog2(`HUB75_PLANES)
`define HUB75_RGB_W   (3 * `HUB75_PLANES)

// longest hold, plane PLANES-1
`define HUB75_HOLD_MAX (`HUB75_BASE_PERIOD << (`HUB75_PLANES - 1))
`define HUB75_HOLD_W   $clog2(`HUB75_HOLD_MAX)

`endif
